/* common/btb_defs.svh */
// Sizing macros for the branch target buffer, included by the package and the RTL blocks
`ifndef BTB_DEFS_SVH
`define BTB_DEFS_SVH

// ----------------------------------------
// Bank geometry
// ----------------------------------------

// Entries per bank
`define BTB_DEPTH 256

// Index is addr[29] plus addr[10:4]
`define BTB_IDX_W 8

// ----------------------------------------
// Fetch group geometry
// ----------------------------------------

`define BTB_SLOTS 4 // Words per fetch group, one bank each

// Width of a slot number
`define BTB_SLOT_W 2

`define BTB_GROUP_BYTES 16 // Byte stride between sequential groups

`endif

/* common/btbPkg.sv */
// Shared types for the fetch prediction stage, imported by every block that moves BTB data
`include "btb_defs.svh"

package btbPkg;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // One BTB entry, target kept as a word address
    typedef struct packed {
        logic        taken;  // Predicted taken
        logic [29:0] target; // Target word address, byte bits dropped
    } btbEntryT;

    // ----------------------------------------
    // Fetch side
    // ----------------------------------------

    // Request from the fetch address generator
    typedef struct packed {
        logic                   valid;
        logic [31:0]            addr; // 16-byte aligned group address
        logic [`BTB_SLOTS-1:0]  mask; // Word enables, bit 0 is lowest word
    } fetchReqT;

    // Registered prediction for one accepted group
    typedef struct packed {
        logic                   valid;         // One cycle per accepted request
        logic [31:0]            nextAddr;      // Next group to fetch
        logic                   taken;         // A taken branch found in this group
        logic [`BTB_SLOT_W-1:0] slot;          // Slot of that branch
        logic [`BTB_SLOTS-1:0]  mask;          // Enables after trimming
        logic                   needDelaySlot; // Slot 3 branch, slot moves to next group
    } predRespT;

    // ----------------------------------------
    // Repair side
    // ----------------------------------------

    // Correction from the back-end branch unit, one Wishbone write
    typedef struct packed {
        logic [31:0] addr;   // Branch instruction address
        logic        taken;  // Resolved direction
        logic [31:0] target; // Resolved byte target
    } repairT;

    // Sequencer states
    typedef enum logic [1:0] {
        INIT  = 2'd0, // Clearing banks after reset
        RUN   = 2'd1, // Normal lookups
        DSLOT = 2'd2  // Fetching delay slot of a slot 3 branch
    } fetchStateT;

endpackage

/* btb/btbBank.sv */
// One BTB bank per word slot with asynchronous read and one write port
`timescale 1ns/1ps
`include "btb_defs.svh"

module btbBank import btbPkg::*; (
    input  logic                  clk,
    input  logic                  rst,       // Only qualifies the assertion
    input  logic [`BTB_IDX_W-1:0] rdIdx_i,   // Lookup index
    output btbEntryT              rdEntry_o, // Same-cycle read data
    input  logic                  wrEn_i,    // Repair or clear write
    input  logic [`BTB_IDX_W-1:0] wrIdx_i,
    input  btbEntryT              wrEntry_i
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Contents undefined until the init sweep has run
    btbEntryT mem [`BTB_DEPTH];

    // Lookup is combinational
    assign rdEntry_o = mem[rdIdx_i];

    // Write lands on the edge and is seen by reads from the next cycle
    always_ff @(posedge clk) begin
        if (wrEn_i) begin
            mem[wrIdx_i] <= wrEntry_i;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // A write with an unknown index would corrupt an unknown entry
    // and the init sweep relies on every index being written once
    wrIdxKnown: assert property (
        @(posedge clk) disable iff (!rst)
        wrEn_i |-> !$isunknown(wrIdx_i)
    ) else $error("btbBank write with X index");

endmodule

/* btb/branchTargetBuffer.sv */
// Four-bank BTB: shared lookup index for the fetch group, bank-selected repair and init clear
`timescale 1ns/1ps
`include "btb_defs.svh"

module branchTargetBuffer import btbPkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [31:0]                    lookupAddr_i,  // Group address
    output btbEntryT [`BTB_SLOTS-1:0]      lookupEntry_o, // One entry per slot
    input  logic                           clrEn_i,       // Init sweep active
    input  logic [`BTB_IDX_W-1:0]          clrIdx_i,      // Index being cleared
    input  logic                           repWr_i,       // Repair write strobe
    input  repairT                         repair_i
);

    // ----------------------------------------
    // Index forming
    // ----------------------------------------

    // addr[29] keeps kseg regions apart, addr[10:4] picks the group
    function automatic logic [`BTB_IDX_W-1:0] groupIdx(input logic [31:0] addr);
        groupIdx = {addr[29], addr[10:4]};
    endfunction

    logic [`BTB_IDX_W-1:0]  lookupIdx;
    logic [`BTB_IDX_W-1:0]  repIdx;
    logic [`BTB_SLOT_W-1:0] repBank;    // Slot of the repaired branch
    logic                   repLive;    // Repair allowed this cycle
    btbEntryT               repEntry;

    assign lookupIdx = groupIdx(lookupAddr_i); // Same index in all banks
    assign repIdx    = groupIdx(repair_i.addr);
    assign repBank   = repair_i.addr[3:2];     // Word within the group
    assign repLive   = repWr_i && !clrEn_i;    // Clear has priority

    // Target stored as word address
    assign repEntry = '{taken: repair_i.taken, target: repair_i.target[31:2]};

    // ----------------------------------------
    // Shared write port data
    // ----------------------------------------

    logic [`BTB_IDX_W-1:0] wrIdx;
    btbEntryT              wrEntry;

    assign wrIdx   = clrEn_i ? clrIdx_i : repIdx;
    assign wrEntry = clrEn_i ? '0 : repEntry; // Zero entry means not taken

    // ----------------------------------------
    // Banks
    // ----------------------------------------

    for (genvar b = 0; b < `BTB_SLOTS; b++) begin : gBank
        logic wrEn;

        // All banks during clear, only the addressed one on repair
        assign wrEn = clrEn_i || (repLive && (repBank == b));

        btbBank uBank (
            .clk       (clk),
            .rst       (rst),
            .rdIdx_i   (lookupIdx),
            .rdEntry_o (lookupEntry_o[b]),
            .wrEn_i    (wrEn),
            .wrIdx_i   (wrIdx),
            .wrEntry_i (wrEntry)
        );
    end

endmodule

/* btb/branchFourToOne.sv */
// Picks the first taken branch in a fetch group, trims the mask and registers the prediction
`timescale 1ns/1ps
`include "btb_defs.svh"

module branchFourToOne import btbPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  fetchReqT                  req_i,         // Valid only when accepted
    input  btbEntryT [`BTB_SLOTS-1:0] entries_i,     // Lookup result per slot
    input  logic                      dslotMode_i,   // Group holds a pending delay slot
    input  logic [31:0]               dslotTarget_i, // Saved slot 3 target
    output logic                      slot3Taken_o,  // Slot 3 branch wins this cycle
    output predRespT                  resp_o
);

    localparam logic [`BTB_SLOTS-1:0] ALL_SLOTS = '1;

    predRespT               nxt;
    logic                   hit;     // Some enabled slot is taken
    logic [`BTB_SLOT_W-1:0] hitSlot; // Lowest such slot
    logic [31:0]            seqAddr;

    assign seqAddr = req_i.addr + 32'(`BTB_GROUP_BYTES); // Fall-through group

    // ----------------------------------------
    // Priority pick and next address
    // ----------------------------------------

    always_comb begin
        hit     = 1'b0;
        hitSlot = '0;
        for (int s = 0; s < `BTB_SLOTS; s++) begin
            if (!hit && req_i.mask[s] && entries_i[s].taken) begin // Lowest enabled wins
                hit     = 1'b1;
                hitSlot = `BTB_SLOT_W'(s);
            end
        end

        nxt          = '0;
        nxt.valid    = req_i.valid;
        nxt.nextAddr = seqAddr;
        nxt.mask     = req_i.mask;

        if (dslotMode_i) begin
            // Only the delay slot word survives, then redirect
            nxt.mask     = req_i.mask & `BTB_SLOTS'(1);
            nxt.nextAddr = dslotTarget_i;
        end else if (hit) begin
            nxt.taken = 1'b1;
            nxt.slot  = hitSlot;
            if (hitSlot == `BTB_SLOT_W'(`BTB_SLOTS - 1)) begin
                nxt.needDelaySlot = 1'b1; // Delay slot lives in next group
            end else begin
                // Keep up to and including the delay slot
                nxt.mask     = req_i.mask & (ALL_SLOTS >> (`BTB_SLOTS - 2 - hitSlot));
                nxt.nextAddr = {entries_i[hitSlot].target, 2'b00};
            end
        end
    end

    assign slot3Taken_o = req_i.valid && !dslotMode_i && nxt.needDelaySlot;

    // One cycle latency to resp_o
    always_ff @(posedge clk) begin
        if (!rst) begin
            resp_o <= '0;
        end else begin
            resp_o <= nxt;
        end
    end

    // Trimming may only drop words, never add
    maskSubset: assert property (
        @(posedge clk) disable iff (!rst)
        req_i.valid |=> (resp_o.mask & ~$past(req_i.mask)) == '0
    ) else $error("branchFourToOne mask grew beyond request");

endmodule

/* design/initSweepCounter.sv */
// Walks every BTB index once after reset so the banks start cleared
`timescale 1ns/1ps
`include "btb_defs.svh"

module initSweepCounter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable_i, // Held by the sequencer during INIT
    output logic [`BTB_IDX_W-1:0] idx_o,    // Index to clear this cycle
    output logic                  done_o    // One cycle after the last index
);

    logic lastIdx;

    assign lastIdx = (idx_o == `BTB_IDX_W'(`BTB_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            idx_o  <= '0;
            done_o <= 1'b0;
        end else begin
            if (enable_i) begin
                idx_o <= idx_o + 1'b1; // Wraps to 0 after the last entry
            end
            done_o <= enable_i && lastIdx;
        end
    end

endmodule

/* design/fetchSeqFsm.sv */
// Fetch sequencer: init clear, normal run and delay-slot fetch, plus Wishbone repair handshake
`timescale 1ns/1ps

module fetchSeqFsm import btbPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sweepDone_i,   // Last index cleared
    output logic        clrEn_o,
    input  logic        reqAccept_i,   // Fetch request taken this edge
    input  logic        slot3Taken_i,
    input  logic [31:0] slot3Target_i,
    output logic        dslotMode_o,
    output logic [31:0] dslotTarget_o,
    output logic        fetchReady_o,
    input  logic        wbCyc_i,
    input  logic        wbStb_i,
    input  logic        wbWe_i,
    output logic        repWr_o,       // Write strobe into the BTB
    output logic        wbAck_o
);

    fetchStateT state;
    fetchStateT stateNxt;
    logic       wbReq;     // New Wishbone access to answer

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_comb begin
        stateNxt = state;
        case (state)
            INIT:    if (sweepDone_i) stateNxt = RUN;
            RUN:     if (reqAccept_i && slot3Taken_i) stateNxt = DSLOT;
            DSLOT:   if (reqAccept_i) stateNxt = RUN; // Delay slot group consumed
            default: stateNxt = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= INIT;
        end else begin
            state <= stateNxt;
        end
    end

    // Redirect target held across the delay slot fetch
    always_ff @(posedge clk) begin
        if (state == RUN && reqAccept_i && slot3Taken_i) begin
            dslotTarget_o <= slot3Target_i;
        end
    end

    assign clrEn_o      = (state == INIT) && !sweepDone_i; // No extra write on done
    assign fetchReady_o = (state != INIT);
    assign dslotMode_o  = (state == DSLOT);

    // ----------------------------------------
    // Wishbone slave
    // ----------------------------------------

    // Master holds the strobe until ack, so mask the cycle ack is up
    assign wbReq   = wbCyc_i && wbStb_i && !wbAck_o && (state != INIT);
    assign repWr_o = wbReq && wbWe_i; // Reads just get acked

    always_ff @(posedge clk) begin
        if (!rst) begin
            wbAck_o <= 1'b0;
        end else begin
            wbAck_o <= wbReq;
        end
    end

    ackSingle: assert property (
        @(posedge clk) disable iff (!rst)
        wbAck_o |=> !wbAck_o
    ) else $error("fetchSeqFsm ack held two cycles");

endmodule

/* design/fetchPredictTop.sv */
// Top of the fetch prediction stage: fetch port, Wishbone repair port and the BTB blocks
`timescale 1ns/1ps
`include "btb_defs.svh"

module fetchPredictTop import btbPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetchReqT    fetchReq_i,
    output logic        fetchReady_o,
    output predRespT    predResp_o,
    input  logic        wbCyc_i,
    input  logic        wbStb_i,
    input  logic        wbWe_i,
    input  logic [31:0] wbAdr_i,   // Branch address
    input  logic [32:0] wbDat_i,   // {taken, target}
    output logic        wbAck_o
);

    logic                      reqAccept;
    fetchReqT                  lookupReq;   // Request gated by acceptance
    repairT                    repair;
    btbEntryT [`BTB_SLOTS-1:0] lookupEntry;
    logic                      clrEn;
    logic [`BTB_IDX_W-1:0]     clrIdx;
    logic                      sweepDone;
    logic                      repWr;
    logic                      slot3Taken;
    logic [31:0]               slot3Target;
    logic                      dslotMode;
    logic [31:0]               dslotTarget;

    assign reqAccept   = fetchReq_i.valid && fetchReady_o;
    assign lookupReq   = '{valid: reqAccept, addr: fetchReq_i.addr, mask: fetchReq_i.mask};
    assign repair      = {wbAdr_i, wbDat_i};
    assign slot3Target = {lookupEntry[`BTB_SLOTS-1].target, 2'b00}; // Byte address

    initSweepCounter uSweep (
        .clk(clk), .rst(rst), .enable_i(clrEn), .idx_o(clrIdx), .done_o(sweepDone)
    );

    branchTargetBuffer uBtb (
        .clk(clk), .rst(rst), .lookupAddr_i(fetchReq_i.addr), .lookupEntry_o(lookupEntry),
        .clrEn_i(clrEn), .clrIdx_i(clrIdx), .repWr_i(repWr), .repair_i(repair)
    );

    branchFourToOne uSel (
        .clk(clk), .rst(rst), .req_i(lookupReq), .entries_i(lookupEntry),
        .dslotMode_i(dslotMode), .dslotTarget_i(dslotTarget),
        .slot3Taken_o(slot3Taken), .resp_o(predResp_o)
    );

    fetchSeqFsm uFsm (
        .clk(clk), .rst(rst), .sweepDone_i(sweepDone), .clrEn_o(clrEn),
        .reqAccept_i(reqAccept), .slot3Taken_i(slot3Taken), .slot3Target_i(slot3Target),
        .dslotMode_o(dslotMode), .dslotTarget_o(dslotTarget), .fetchReady_o(fetchReady_o),
        .wbCyc_i(wbCyc_i), .wbStb_i(wbStb_i), .wbWe_i(wbWe_i),
        .repWr_o(repWr), .wbAck_o(wbAck_o)
    );

endmodule

/* verif/fetchPredictTb.sv */
// Testbench for fetchPredictTop with a reference BTB model, fetch and Wishbone stimulus and checks
`timescale 1ns/1ps
`include "btb_defs.svh"

module fetchPredictTb import btbPkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RAND_OPS   = 200;
    localparam int NUM_OPS    = 8 + 3 + 6 + 4 + 4 + RAND_OPS; // Fetches plus bus accesses

    logic        clk;
    logic        rst;
    fetchReqT    fetchReq_i;
    logic        fetchReady_o;
    predRespT    predResp_o;
    logic        wbCyc_i;
    logic        wbStb_i;
    logic        wbWe_i;
    logic [31:0] wbAdr_i;
    logic [32:0] wbDat_i;
    logic        wbAck_o;

    // Reference state written only on acknowledged writes
    logic        modelTaken  [`BTB_SLOTS][`BTB_DEPTH];
    logic [29:0] modelTarget [`BTB_SLOTS][`BTB_DEPTH];
    logic        dslotPending;  // Slot 3 branch seen and delay slot group due next
    logic [31:0] dslotSaved;
    predRespT    expResp;       // Prediction expected for the request on the bus
    integer      seed;
    int          errCount, testStartErr, passCount, failCount, ackCount;
    logic        accepted;

    fetchPredictTop u_dut (
        .clk(clk), .rst(rst), .fetchReq_i(fetchReq_i), .fetchReady_o(fetchReady_o),
        .predResp_o(predResp_o), .wbCyc_i(wbCyc_i), .wbStb_i(wbStb_i), .wbWe_i(wbWe_i),
        .wbAdr_i(wbAdr_i), .wbDat_i(wbDat_i), .wbAck_o(wbAck_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) if (wbAck_o) ackCount++; // Acks seen on the bus

    // ----------------------------------------
    // Response checks
    // ----------------------------------------

    assign accepted = fetchReq_i.valid && fetchReady_o;

    respMatches: assert property (
        @(posedge clk) disable iff (!rst)
        accepted |=> (predResp_o == $past(expResp))
    ) else begin
        $display("ERR %0t: prediction %h, expected %h", $time, $sampled(predResp_o), expResp);
        errCount++;
    end

    // Valid only ever follows an accepted request
    noStrayResp: assert property (
        @(posedge clk) disable iff (!rst)
        !accepted |=> !predResp_o.valid
    ) else begin
        $display("ERR %0t: response valid without an accepted request", $time);
        errCount++;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [7:0] groupIndex(input logic [31:0] addr);
        return {addr[29], addr[10:4]}; // Region bit plus group bits
    endfunction

    function automatic predRespT expectedResp(input logic [31:0] addr, input logic [3:0] mask);
        predRespT   r;
        logic [7:0] idx;
        int         first;
        idx        = groupIndex(addr);
        first      = -1;
        r          = '0;
        r.valid    = 1'b1;
        r.mask     = mask;
        r.nextAddr = addr + 32'd16; // Fall through by default
        for (int s = `BTB_SLOTS - 1; s >= 0; s--) begin
            if (mask[s] && modelTaken[s][idx]) first = s; // Ends on lowest
        end
        if (dslotPending) begin
            r.mask     = mask & 4'b0001; // Delay slot word only
            r.nextAddr = dslotSaved;
        end else if (first == 3) begin
            r.taken         = 1'b1;
            r.slot          = 2'd3;
            r.needDelaySlot = 1'b1;
        end else if (first >= 0) begin
            r.taken    = 1'b1;
            r.slot     = 2'(first);
            r.mask     = mask & 4'((5'b00100 << first) - 5'd1); // Branch plus delay slot
            r.nextAddr = {modelTarget[first][idx], 2'b00};
        end
        return r;
    endfunction

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------

    task automatic doFetch(input logic [31:0] addr, input logic [3:0] mask, output predRespT got);
        logic [7:0] idx;
        idx = groupIndex(addr);
        @(negedge clk);
        assert (fetchReady_o) else begin
            $display("Fetch request issued while the stage was not ready");
            errCount++;
        end
        expResp    = expectedResp(addr, mask);
        fetchReq_i = '{valid: 1'b1, addr: addr, mask: mask};
        @(negedge clk);
        fetchReq_i.valid = 1'b0;
        got              = predResp_o; // Registered on the accept edge
        if (expResp.needDelaySlot) begin
            dslotPending = 1'b1;
            dslotSaved   = {modelTarget[3][idx], 2'b00};
        end else begin
            dslotPending = 1'b0; // Any accepted group ends a delay slot fetch
        end
    endtask

    task automatic wbAccess(input logic we, input logic [31:0] addr, input logic taken,
                            input logic [31:0] target);
        int   waited;
        logic acked;
        @(negedge clk);
        wbCyc_i = 1'b1;
        wbStb_i = 1'b1;
        wbWe_i  = we;
        wbAdr_i = addr;
        wbDat_i = {taken, target};
        waited  = 0;
        acked   = 1'b0;
        while (!acked && waited < 20) begin // Master holds until ack
            @(negedge clk);
            waited++;
            acked = wbAck_o;
        end
        wbCyc_i = 1'b0;
        wbStb_i = 1'b0;
        wbWe_i  = 1'b0;
        if (!acked) begin
            $display("Wishbone access to %h was never acknowledged", addr);
            errCount++;
        end else begin
            assert (waited == 1) else begin
                $display("ERR %0t: ack after %0d cycles, expected 1", $time, waited);
                errCount++;
            end
            if (we) begin
                modelTaken[addr[3:2]][groupIndex(addr)]  = taken;
                modelTarget[addr[3:2]][groupIndex(addr)] = target[31:2];
            end
        end
    endtask

    task automatic finishTest(input string name);
        int errs;
        repeat (2) @(posedge clk); // Let the last response check fire
        errs = errCount - testStartErr;
        if (errs == 0) begin
            passCount++;
            $display("Test %s: ok", name);
        end else begin
            failCount++;
            $display("Test %s: %0d error(s)", name, errs);
        end
        testStartErr = errCount;
    endtask

    // ----------------------------------------
    // Watchdog
    // ----------------------------------------

    initial begin
        #((`BTB_DEPTH + 10 + 40 * NUM_OPS) * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        predRespT    got;
        logic [31:0] pick, addr;
        int          initCycles, acksBefore;
        clk = 1'b0;
        rst = 1'b0;
        fetchReq_i = '0;
        {wbCyc_i, wbStb_i, wbWe_i, wbAdr_i, wbDat_i} = '0;
        {errCount, testStartErr, passCount, failCount, ackCount} = '0;
        expResp = '0;
        dslotPending = 1'b0;
        dslotSaved   = '0;
        seed = 88;
        for (int b = 0; b < `BTB_SLOTS; b++) begin
            for (int i = 0; i < `BTB_DEPTH; i++) begin
                modelTaken[b][i]  = 1'b0; // Sweep leaves everything not taken
                modelTarget[b][i] = '0;
            end
        end

        // Test 1 covers init sweep length and cleared lookups
        repeat (10) @(negedge clk);
        assert (!fetchReady_o && !wbAck_o && !predResp_o.valid) else begin
            $display("ERR %0t: outputs not low during reset", $time);
            errCount++;
        end
        rst = 1'b1;
        initCycles = 0;
        while (!fetchReady_o && initCycles < 400) begin
            @(negedge clk);
            initCycles++;
        end
        assert (initCycles == `BTB_DEPTH + 1) else begin
            $display("ERR %0t: fetchReady_o after %0d edges, expected 257", $time, initCycles);
            errCount++;
        end
        for (int i = 0; i < 8; i++) begin
            doFetch(32'h0040_0000 + i * 32'h110, 4'hF >> i[1:0], got);
        end
        finishTest("1 init sweep");

        // Test 2 covers write and read handshakes, then a taken lookup
        acksBefore = ackCount;
        wbAccess(1'b1, 32'h0040_1234, 1'b1, 32'h0000_5A40); // Slot 1
        wbAccess(1'b0, 32'h0040_1234, 1'b1, 32'h0BAD_0000); // Read must leave the entry alone
        repeat (3) @(posedge clk);
        assert (ackCount - acksBefore == 2) else begin
            $display("ERR %0t: %0d acks for 2 accesses", $time, ackCount - acksBefore);
            errCount++;
        end
        doFetch(32'h0040_1230, 4'hF, got);
        finishTest("2 write and lookup");

        // Test 3 covers slot priority and disabled slots
        wbAccess(1'b1, 32'h2000_2360, 1'b1, 32'h0000_3000);
        wbAccess(1'b1, 32'h2000_2364, 1'b1, 32'h0000_3100);
        wbAccess(1'b1, 32'h2000_2368, 1'b1, 32'h0000_3200);
        doFetch(32'h2000_2360, 4'b1111, got);
        doFetch(32'h2000_2360, 4'b1110, got);
        doFetch(32'h2000_2360, 4'b1100, got);
        finishTest("3 first taken slot");

        // Test 4 runs a slot 3 branch, its delay slot group and a normal group
        wbAccess(1'b1, 32'h0000_4A8C, 1'b1, 32'h0001_0100);
        doFetch(32'h0000_4A80, 4'hF, got);
        doFetch(32'h0000_4A90, 4'hF, got);
        assert (got.mask == 4'b0001 && got.nextAddr == 32'h0001_0100) else begin
            $display("ERR %0t: delay slot group gave %h", $time, got);
            errCount++;
        end
        doFetch(32'h0000_4A90, 4'hF, got);
        finishTest("4 slot 3 delay slot");

        // Test 5 covers aliasing through the untagged index
        wbAccess(1'b1, 32'h0000_0654, 1'b1, 32'h0000_7700);
        wbAccess(1'b1, 32'hDFFF_FE54, 1'b1, 32'h0000_8800); // Same index and slot
        doFetch(32'h0000_0650, 4'hF, got);
        assert (got.nextAddr == 32'h0000_8800) else begin
            $display("ERR %0t: alias lookup went to %h", $time, got.nextAddr);
            errCount++;
        end
        doFetch(32'hDFFF_FE50, 4'hF, got);
        finishTest("5 aliasing");

        // Test 6 mixes random accesses on a small set of groups so hits are common
        for (int n = 0; n < RAND_OPS; n++) begin
            pick = $random(seed);
            addr = $random(seed) & 32'hA000_007C;
            if (pick[2:0] == 3'd0) begin
                wbAccess(1'b0, addr, 1'b0, 32'h0);
            end else if (pick[2:0] < 3'd4) begin
                wbAccess(1'b1, addr, pick[3], $random(seed) & ~32'h3);
            end else begin
                doFetch(addr & ~32'hF, pick[7:4], got);
            end
        end
        finishTest("6 random");

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 passCount, failCount, errCount);
        if (errCount == 0 && failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/btbPkg.sv
btb/btbBank.sv
btb/branchTargetBuffer.sv
btb/branchFourToOne.sv
design/initSweepCounter.sv
design/fetchSeqFsm.sv
design/fetchPredictTop.sv
verif/fetchPredictTb.sv

/* Makefile */
# Verilator build and run for the fetch prediction stage

VERILATOR ?= verilator
TOP       ?= fetchPredictTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
